//--- hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // Geometry --------------------
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int ID_W       = 8;
  localparam int N_WAYS     = 2;
  localparam int WAY_W      = $clog2(N_WAYS);
  localparam int LINE_WORDS = 4;
  localparam int N_SETS     = 32;

  // Address split: tag | index | word select | byte
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 5;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WSEL_W     = $clog2(LINE_WORDS);
  localparam int BYTE_W     = OFFSET_W - WSEL_W;

  localparam int AR_BUF_DEPTH = 2;

  // AXI read constants --------------------
  localparam int             AXI_ID_W       = 4;
  localparam logic [7:0]     AXI_LEN_LINE   = 8'd3;   // Four beats
  localparam logic [7:0]     AXI_LEN_WORD   = 8'd0;   // Single beat
  localparam logic [2:0]     AXI_SIZE_WORD  = 3'd2;   // 4 bytes per beat
  localparam logic [1:0]     AXI_BURST_INCR = 2'b01;
  localparam logic [AXI_ID_W-1:0] AXI_ARID  = '0;

  // Shared types --------------------
  typedef logic [WORD_W-1:0] word_t;

  // Word 0 sits at the lowest address
  typedef word_t [LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } fetch_req_t;

  typedef struct packed {
    word_t           data;
    logic [ID_W-1:0] id;
  } fetch_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } ar_req_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } r_beat_t;

endpackage

`default_nettype wire

//--- hdl/icache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
  parameter type payload_t = logic
) (
  input  wire logic                           clk_i,
  input  wire logic                           re_i,
  input  wire logic [icache_pkg::INDEX_W-1:0] raddr_i,
  output payload_t                            rdata_o,
  input  wire logic                           we_i,
  input  wire logic [icache_pkg::INDEX_W-1:0] waddr_i,
  input  wire payload_t                       wdata_i
);

  payload_t mem [icache_pkg::N_SETS];

  // One entry per set, contents become meaningful after a flush
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem[waddr_i] <= wdata_i;
    end
    if (re_i)
    begin
      rdata_o <= mem[raddr_i];  // Data one cycle after enable
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,

  // Fetch side
  input  wire logic                    fetch_req_i,
  input  wire icache_pkg::fetch_req_t  fetch_i,
  output logic                         fetch_grant_o,
  output logic                         fetch_r_valid_o,
  output icache_pkg::fetch_rsp_t       fetch_r_o,

  // Control
  input  wire logic                    ctrl_req_enable_i,
  output logic                         ctrl_ack_enable_o,
  input  wire logic                    ctrl_req_disable_i,
  output logic                         ctrl_ack_disable_o,
  output logic                         ctrl_pending_o,

  // Read requests and refill lines
  output logic                         ar_valid_o,
  input  wire logic                    ar_ready_i,
  output icache_pkg::ar_req_t          ar_o,
  input  wire logic                    line_valid_i,
  output logic                         line_ready_o,
  input  wire icache_pkg::line_t       line_i,

  // Tag RAMs
  output logic [icache_pkg::N_WAYS-1:0]  tag_re_o,
  output logic [icache_pkg::N_WAYS-1:0]  tag_we_o,
  output logic [icache_pkg::INDEX_W-1:0] tag_raddr_o,
  output logic [icache_pkg::INDEX_W-1:0] tag_waddr_o,
  output icache_pkg::tag_entry_t         tag_wdata_o,
  input  wire icache_pkg::tag_entry_t [icache_pkg::N_WAYS-1:0] tag_rdata_i,

  // Data RAMs
  output logic [icache_pkg::N_WAYS-1:0]  data_re_o,
  output logic [icache_pkg::N_WAYS-1:0]  data_we_o,
  output logic [icache_pkg::INDEX_W-1:0] data_raddr_o,
  output logic [icache_pkg::INDEX_W-1:0] data_waddr_o,
  output icache_pkg::line_t              data_wdata_o,
  input  wire icache_pkg::line_t [icache_pkg::N_WAYS-1:0] data_rdata_i
);

  typedef enum logic [2:0] {
    S_DIS_IDLE,
    S_BYP_REQ,
    S_BYP_WAIT,
    S_FLUSH,
    S_IDLE,
    S_LOOKUP,
    S_MISS_REQ,
    S_REFILL_WAIT
  } state_e;

  state_e                           state_q, state_d;
  icache_pkg::fetch_req_t           req_q;
  icache_pkg::fetch_rsp_t           rsp_q;
  logic                             rsp_valid_q, rsp_set;
  icache_pkg::word_t                rsp_word;
  logic                             pending_q;
  logic                             ack_en_q, ack_en_d;
  logic                             ack_dis_q, ack_dis_d;
  logic [icache_pkg::INDEX_W-1:0]   flush_cnt_q;
  logic [icache_pkg::N_SETS-1:0]    rr_q;     // Victim way per set
  logic                             refill;

  // Address fields of the held request
  logic [icache_pkg::INDEX_W-1:0]   req_idx;
  logic [icache_pkg::TAG_W-1:0]     req_tag;
  logic [icache_pkg::WSEL_W-1:0]    req_wsel;
  logic [icache_pkg::ADDR_W-1:0]    line_addr;

  logic [icache_pkg::N_WAYS-1:0]    hit;
  logic [icache_pkg::WAY_W-1:0]     hit_way;
  icache_pkg::word_t                hit_word;
  logic [icache_pkg::WAY_W-1:0]     victim;
  logic [icache_pkg::N_WAYS-1:0]    victim_oh;

  assign req_idx   = req_q.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign req_tag   = req_q.addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign req_wsel  = req_q.addr[icache_pkg::BYTE_W +: icache_pkg::WSEL_W];
  assign line_addr = {req_q.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                      {icache_pkg::OFFSET_W{1'b0}}};

  // Tag compare and way select --------------------
  always_comb
  begin
    hit     = '0;
    hit_way = '0;
    for (int w = 0; w < icache_pkg::N_WAYS; w++)
    begin
      hit[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == req_tag);
      if (hit[w])
      begin
        hit_way = icache_pkg::WAY_W'(w);
      end
    end
  end

  assign hit_word  = data_rdata_i[hit_way][req_wsel];
  assign victim    = icache_pkg::WAY_W'(rr_q[req_idx]);
  assign victim_oh = icache_pkg::N_WAYS'(1) << victim;

  // Reads always use the incoming fetch index, taken on grant only
  assign tag_raddr_o  = fetch_i.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign data_raddr_o = tag_raddr_o;
  assign tag_waddr_o  = (state_q == S_FLUSH) ? flush_cnt_q : req_idx;
  assign data_waddr_o = req_idx;
  assign tag_wdata_o  = '{valid: (state_q != S_FLUSH), tag: req_tag};  // Flush writes invalid
  assign data_wdata_o = line_i;

  // FSM --------------------
  always_comb
  begin
    state_d       = state_q;
    fetch_grant_o = 1'b0;
    tag_re_o      = '0;
    data_re_o     = '0;
    tag_we_o      = '0;
    data_we_o     = '0;
    ar_valid_o    = 1'b0;
    ar_o          = '{addr: line_addr, len: icache_pkg::AXI_LEN_LINE};
    line_ready_o  = 1'b0;
    rsp_set       = 1'b0;
    rsp_word      = hit_word;
    refill        = 1'b0;
    ack_en_d      = 1'b0;
    ack_dis_d     = 1'b0;

    unique case (state_q)
      S_DIS_IDLE:
      begin
        if (ctrl_req_enable_i && !ack_en_q)
        begin
          state_d = S_FLUSH;
        end
        else if (ctrl_req_disable_i && !ack_dis_q)
        begin
          ack_dis_d = 1'b1;                 // Already disabled
        end
        else if (fetch_req_i)
        begin
          fetch_grant_o = 1'b1;
          state_d       = S_BYP_REQ;
        end
      end

      S_BYP_REQ:
      begin
        ar_valid_o = 1'b1;
        ar_o       = '{addr: req_q.addr, len: icache_pkg::AXI_LEN_WORD};
        if (ar_ready_i)
        begin
          state_d = S_BYP_WAIT;
        end
      end

      S_BYP_WAIT:
      begin
        line_ready_o = 1'b1;
        rsp_word     = line_i[0];           // Single beat lands in word 0
        if (line_valid_i)
        begin
          rsp_set = 1'b1;
          state_d = S_DIS_IDLE;
        end
      end

      S_FLUSH:
      begin
        tag_we_o = '1;
        if (flush_cnt_q == icache_pkg::INDEX_W'(icache_pkg::N_SETS - 1))
        begin
          ack_en_d = 1'b1;
          state_d  = S_IDLE;
        end
      end

      S_IDLE:
      begin
        if (ctrl_req_enable_i && !ack_en_q)
        begin
          state_d = S_FLUSH;
        end
        else if (ctrl_req_disable_i && !ack_dis_q)
        begin
          ack_dis_d = 1'b1;
          state_d   = S_DIS_IDLE;
        end
        else if (fetch_req_i)
        begin
          fetch_grant_o = 1'b1;
          tag_re_o      = '1;
          data_re_o     = '1;
          state_d       = S_LOOKUP;
        end
      end

      S_LOOKUP:
      begin
        if (|hit)
        begin
          rsp_set = 1'b1;
          state_d = S_IDLE;
        end
        else
        begin
          state_d = S_MISS_REQ;
        end
      end

      S_MISS_REQ:
      begin
        ar_valid_o = 1'b1;
        if (ar_ready_i)
        begin
          state_d = S_REFILL_WAIT;
        end
      end

      S_REFILL_WAIT:
      begin
        line_ready_o = 1'b1;
        rsp_word     = line_i[req_wsel];
        if (line_valid_i)
        begin
          tag_we_o  = victim_oh;
          data_we_o = victim_oh;
          refill    = 1'b1;
          rsp_set   = 1'b1;
          state_d   = S_IDLE;
        end
      end

      default:
      begin
        state_d = S_DIS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= S_DIS_IDLE;            // Cache starts disabled
      rsp_valid_q <= 1'b0;
      pending_q   <= 1'b0;
      ack_en_q    <= 1'b0;
      ack_dis_q   <= 1'b0;
      flush_cnt_q <= '0;
      rr_q        <= '0;
    end
    else
    begin
      state_q     <= state_d;
      rsp_valid_q <= rsp_set;
      ack_en_q    <= ack_en_d;
      ack_dis_q   <= ack_dis_d;
      if (fetch_grant_o)
      begin
        pending_q <= 1'b1;
      end
      else if (rsp_set)
      begin
        pending_q <= 1'b0;
      end
      if (state_q == S_FLUSH)
      begin
        flush_cnt_q <= flush_cnt_q + 1'b1;  // Wraps back to 0 after the last set
        rr_q        <= '0;
      end
      else if (refill)
      begin
        rr_q[req_idx] <= ~rr_q[req_idx];
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i)
  begin
    if (fetch_grant_o)
    begin
      req_q <= fetch_i;
    end
    if (rsp_set)
    begin
      rsp_q <= '{data: rsp_word, id: req_q.id};
    end
  end

  assign fetch_r_valid_o    = rsp_valid_q;
  assign fetch_r_o          = rsp_q;
  assign ctrl_pending_o     = pending_q;
  assign ctrl_ack_enable_o  = ack_en_q;
  assign ctrl_ack_disable_o = ack_dis_q;

endmodule

`default_nettype wire

//--- hdl/refill_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module refill_deserializer (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  // AXI R channel
  input  wire logic                r_valid_i,
  output logic                     r_ready_o,
  input  wire icache_pkg::r_beat_t r_i,

  // Assembled line
  output logic                     line_valid_o,
  input  wire logic                line_ready_i,
  output icache_pkg::line_t        line_o
);

  logic [icache_pkg::WSEL_W-1:0] beat_q;
  logic                          full_q;
  logic                          beat_take;
  icache_pkg::line_t             line_q;

  // R stalls while a finished line waits
  assign r_ready_o = !full_q;
  assign beat_take = r_valid_i && r_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      beat_q <= '0;
      full_q <= 1'b0;
    end
    else
    begin
      if (beat_take)
      begin
        beat_q <= r_i.last ? '0 : beat_q + 1'b1;
      end
      if (beat_take && r_i.last)
      begin
        full_q <= 1'b1;
      end
      else if (full_q && line_ready_i)
      begin
        full_q <= 1'b0;                     // Line handed over
      end
    end
  end

  // Beat k goes to word k
  always_ff @(posedge clk_i)
  begin
    if (beat_take)
    begin
      line_q[beat_q] <= r_i.data;
    end
  end

  assign line_valid_o = full_q;
  assign line_o       = line_q;

endmodule

`default_nettype wire

//--- hdl/axi_ar_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ar_buffer (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  // From the controller
  input  wire logic                in_valid_i,
  output logic                     in_ready_o,
  input  wire icache_pkg::ar_req_t in_i,

  // To the AR channel
  output logic                     out_valid_o,
  input  wire logic                out_ready_i,
  output icache_pkg::ar_req_t      out_o
);

  icache_pkg::ar_req_t mem [icache_pkg::AR_BUF_DEPTH];

  logic [$clog2(icache_pkg::AR_BUF_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(icache_pkg::AR_BUF_DEPTH+1)-1:0] count_q;
  logic                                          push, pop;

  assign in_ready_o  = (count_q != icache_pkg::AR_BUF_DEPTH);
  assign out_valid_o = (count_q != '0);
  assign out_o       = mem[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem[wr_ptr_q] <= in_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,

  // Fetch port
  input  wire logic                          fetch_req_i,
  input  wire icache_pkg::fetch_req_t        fetch_i,
  output logic                               fetch_grant_o,
  output logic                               fetch_r_valid_o,
  output icache_pkg::fetch_rsp_t             fetch_r_o,

  // AXI AR channel
  output logic                               ar_valid_o,
  input  wire logic                          ar_ready_i,
  output icache_pkg::ar_req_t                ar_o,
  output logic [icache_pkg::AXI_ID_W-1:0]    ar_id_o,
  output logic [2:0]                         ar_size_o,
  output logic [1:0]                         ar_burst_o,

  // AXI R channel
  input  wire logic                          r_valid_i,
  output logic                               r_ready_o,
  input  wire icache_pkg::r_beat_t           r_i,

  // Control
  input  wire logic                          ctrl_req_enable_i,
  output logic                               ctrl_ack_enable_o,
  input  wire logic                          ctrl_req_disable_i,
  output logic                               ctrl_ack_disable_o,
  output logic                               ctrl_pending_o
);

  logic                                          req_valid, req_ready;
  icache_pkg::ar_req_t                           req_ar;
  logic                                          line_valid, line_ready;
  icache_pkg::line_t                             line;

  logic [icache_pkg::N_WAYS-1:0]                 tag_re, tag_we;
  logic [icache_pkg::INDEX_W-1:0]                tag_raddr, tag_waddr;
  icache_pkg::tag_entry_t                        tag_wdata;
  icache_pkg::tag_entry_t [icache_pkg::N_WAYS-1:0] tag_rdata;

  logic [icache_pkg::N_WAYS-1:0]                 data_re, data_we;
  logic [icache_pkg::INDEX_W-1:0]                data_raddr, data_waddr;
  icache_pkg::line_t                             data_wdata;
  icache_pkg::line_t [icache_pkg::N_WAYS-1:0]    data_rdata;

  icache_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_i            (fetch_i),
    .fetch_grant_o      (fetch_grant_o),
    .fetch_r_valid_o    (fetch_r_valid_o),
    .fetch_r_o          (fetch_r_o),
    .ctrl_req_enable_i  (ctrl_req_enable_i),
    .ctrl_ack_enable_o  (ctrl_ack_enable_o),
    .ctrl_req_disable_i (ctrl_req_disable_i),
    .ctrl_ack_disable_o (ctrl_ack_disable_o),
    .ctrl_pending_o     (ctrl_pending_o),
    .ar_valid_o         (req_valid),
    .ar_ready_i         (req_ready),
    .ar_o               (req_ar),
    .line_valid_i       (line_valid),
    .line_ready_o       (line_ready),
    .line_i             (line),
    .tag_re_o           (tag_re),
    .tag_we_o           (tag_we),
    .tag_raddr_o        (tag_raddr),
    .tag_waddr_o        (tag_waddr),
    .tag_wdata_o        (tag_wdata),
    .tag_rdata_i        (tag_rdata),
    .data_re_o          (data_re),
    .data_we_o          (data_we),
    .data_raddr_o       (data_raddr),
    .data_waddr_o       (data_waddr),
    .data_wdata_o       (data_wdata),
    .data_rdata_i       (data_rdata)
  );

  // Both refills and bypass reads pass here
  refill_deserializer u_deser (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_i          (r_i),
    .line_valid_o (line_valid),
    .line_ready_i (line_ready),
    .line_o       (line)
  );

  axi_ar_buffer u_ar_buf (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid),
    .in_ready_o  (req_ready),
    .in_i        (req_ar),
    .out_valid_o (ar_valid_o),
    .out_ready_i (ar_ready_i),
    .out_o       (ar_o)
  );

  // Per-way RAMs --------------------
  for (genvar w = 0; w < icache_pkg::N_WAYS; w++)
  begin : g_way
    icache_ram #(.payload_t(icache_pkg::tag_entry_t)) u_tag_ram (
      .clk_i   (clk_i),
      .re_i    (tag_re[w]),
      .raddr_i (tag_raddr),
      .rdata_o (tag_rdata[w]),
      .we_i    (tag_we[w]),
      .waddr_i (tag_waddr),
      .wdata_i (tag_wdata)
    );

    icache_ram #(.payload_t(icache_pkg::line_t)) u_data_ram (
      .clk_i   (clk_i),
      .re_i    (data_re[w]),
      .raddr_i (data_raddr),
      .rdata_o (data_rdata[w]),
      .we_i    (data_we[w]),
      .waddr_i (data_waddr),
      .wdata_i (data_wdata)
    );
  end

  // Fixed AR attributes
  assign ar_id_o    = icache_pkg::AXI_ARID;
  assign ar_size_o  = icache_pkg::AXI_SIZE_WORD;
  assign ar_burst_o = icache_pkg::AXI_BURST_INCR;

endmodule

`default_nettype wire

//--- sim/axi_rd_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_slave (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic [7:0]          stall_pct_i,  // Chance of a gap per cycle, in percent
  input  wire logic                ar_valid_i,
  output logic                     ar_ready_o,
  input  wire icache_pkg::ar_req_t ar_i,
  output logic                     r_valid_o,
  input  wire logic                r_ready_i,
  output icache_pkg::r_beat_t      r_o,
  output int                       ar_count_o,
  output icache_pkg::ar_req_t      last_ar_o
);

  integer              seed;
  logic                busy;
  logic                ar_fire;
  logic                r_fire;
  logic                rst_seen;
  logic [31:0]         addr;
  int                  beats_left;
  icache_pkg::ar_req_t ar_req;

  function automatic logic take_gap();
    return ($unsigned($random(seed)) % 100) < stall_pct_i;
  endfunction

  // Memory content is a function of the word address
  function automatic icache_pkg::word_t word_at(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'hC0DE0000;
  endfunction

  initial
  begin
    seed       = 32'h402a;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    busy       = 1'b0;
    addr       = '0;
    beats_left = 0;
    ar_count_o = 0;
    last_ar_o  = '0;
    forever
    begin
      // Handshakes are seen at the rising edge, outputs change at the falling edge
      @(posedge clk_i);
      ar_fire  = ar_valid_i && ar_ready_o;
      r_fire   = r_valid_o && r_ready_i;
      ar_req   = ar_i;
      rst_seen = rst_n_i;
      @(negedge clk_i);
      if (!rst_seen)
      begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        busy       = 1'b0;
      end
      else
      begin
        if (ar_fire)
        begin
          busy       = 1'b1;
          addr       = ar_req.addr;
          beats_left = ar_req.len + 1;
          ar_count_o = ar_count_o + 1;
          last_ar_o  = ar_req;
        end
        if (r_fire)
        begin
          addr       = addr + 4;  // INCR burst
          beats_left = beats_left - 1;
          busy       = (beats_left != 0);
        end
        ar_ready_o = !busy && !take_gap();
        if (!(r_valid_o && !r_fire))  // A beat on offer stays until taken
        begin
          r_valid_o = busy && !take_gap();
          r_o       = '{data: word_at(addr), last: (beats_left == 1)};
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int MAX_FETCHES      = 60;
  localparam int MAX_FETCH_CYCLES = 200;
  localparam int TIMEOUT_CYCLES   = MAX_FETCHES * MAX_FETCH_CYCLES + 8000;  // Flushes and margin

  logic                            clk;
  logic                            rst_n;
  logic                            fetch_req;
  logic                            fetch_grant;
  logic                            fetch_r_valid;
  icache_pkg::fetch_req_t          fetch_in;
  icache_pkg::fetch_rsp_t          fetch_r;
  logic                            ar_valid;
  logic                            ar_ready;
  icache_pkg::ar_req_t             ar;
  logic [icache_pkg::AXI_ID_W-1:0] ar_id;
  logic [2:0]                      ar_size;
  logic [1:0]                      ar_burst;
  logic                            r_valid;
  logic                            r_ready;
  icache_pkg::r_beat_t             r;
  logic                            req_en;
  logic                            ack_en;
  logic                            req_dis;
  logic                            ack_dis;
  logic                            pending;
  logic [7:0]                      stall_pct;
  int                              ar_count;
  icache_pkg::ar_req_t             last_ar;
  int                              cycles;
  int                              errors;
  int                              test_errors;
  int                              tests_run;

  icache_top dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .fetch_req_i        (fetch_req),
    .fetch_i            (fetch_in),
    .fetch_grant_o      (fetch_grant),
    .fetch_r_valid_o    (fetch_r_valid),
    .fetch_r_o          (fetch_r),
    .ar_valid_o         (ar_valid),
    .ar_ready_i         (ar_ready),
    .ar_o               (ar),
    .ar_id_o            (ar_id),
    .ar_size_o          (ar_size),
    .ar_burst_o         (ar_burst),
    .r_valid_i          (r_valid),
    .r_ready_o          (r_ready),
    .r_i                (r),
    .ctrl_req_enable_i  (req_en),
    .ctrl_ack_enable_o  (ack_en),
    .ctrl_req_disable_i (req_dis),
    .ctrl_ack_disable_o (ack_dis),
    .ctrl_pending_o     (pending)
  );

  axi_rd_slave u_mem (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .stall_pct_i (stall_pct),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_i        (ar),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_o         (r),
    .ar_count_o  (ar_count),
    .last_ar_o   (last_ar)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Every accepted AR carries the fixed attributes
  always @(posedge clk)
  begin
    if (rst_n && ar_valid && ar_ready)
    begin
      check_ar_attrs("AR attributes", icache_pkg::AXI_ARID, 3'd2, 2'b01,
                     ar_id, ar_size, ar_burst);  // 4-byte beats, INCR burst
    end
  end

  function automatic icache_pkg::word_t expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hC0DE0000;
  endfunction

  // Compare tasks --------------------
  task automatic check_word(input string name, input icache_pkg::word_t exp,
                            input icache_pkg::word_t act);
    if (act !== exp)
    begin
      $display("Mismatch in %s: data expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input logic [icache_pkg::ID_W-1:0] exp,
                          input logic [icache_pkg::ID_W-1:0] act);
    if (act !== exp)
    begin
      $display("Mismatch in %s: id expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_ar(input string name, input icache_pkg::ar_req_t exp,
                          input icache_pkg::ar_req_t act);
    if (act !== exp)
    begin
      $display("Mismatch in %s: expected addr %h len %0d, actual addr %h len %0d",
               name, exp.addr, exp.len, act.addr, act.len);
      errors++;
    end
  endtask

  task automatic check_ar_attrs(input string name,
                                input logic [icache_pkg::AXI_ID_W-1:0] exp_id,
                                input logic [2:0] exp_size, input logic [1:0] exp_burst,
                                input logic [icache_pkg::AXI_ID_W-1:0] act_id,
                                input logic [2:0] act_size, input logic [1:0] act_burst);
    if (act_id !== exp_id || act_size !== exp_size || act_burst !== exp_burst)
    begin
      $display("Mismatch in %s: expected id/size/burst %h/%0d/%0d, actual %h/%0d/%0d",
               name, exp_id, exp_size, exp_burst, act_id, act_size, act_burst);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // Driver tasks --------------------
  // A negative exp_lat skips the latency check
  task automatic fetch_and_check(input string name, input logic [31:0] addr,
                                 input logic [7:0] id, input int new_ars, input int exp_lat);
    int t_grant;
    int ar_before;
    ar_before = ar_count;
    @(negedge clk);
    fetch_req = 1'b1;
    fetch_in  = '{addr: addr, id: id};
    do
      @(posedge clk);
    while (!fetch_grant);
    t_grant = cycles;
    @(negedge clk);
    fetch_req = 1'b0;
    do
      @(posedge clk);
    while (!fetch_r_valid);
    check_word(name, expected_word(addr), fetch_r.data);
    check_id(name, id, fetch_r.id);
    if (exp_lat >= 0)
      check_count({name, " latency"}, exp_lat, cycles - t_grant);
    @(negedge clk);  // Slave counters settle here
    check_count({name, " AR count"}, new_ars, ar_count - ar_before);
  endtask

  task automatic request_mode(input logic enable);
    @(negedge clk);
    req_en  = enable;
    req_dis = !enable;
    do
      @(posedge clk);
    while (!(enable ? ack_en : ack_dis));
    @(negedge clk);
    req_en  = 1'b0;
    req_dis = 1'b0;
  endtask

  // Tests --------------------
  task automatic test_bypass();
    logic [31:0] addrs [3];
    addrs = '{32'h0000_0100, 32'h0000_0104, 32'h0000_2008};
    for (int i = 0; i < 3; i++)
    begin
      fetch_and_check("bypass", addrs[i], 8'(8'h10 + i), 1, -1);
      check_ar("bypass AR", '{addr: addrs[i], len: icache_pkg::AXI_LEN_WORD}, last_ar);
    end
    finish_test("bypass");
  endtask

  task automatic test_enable();
    request_mode(1'b1);
    repeat (4)
    begin
      @(posedge clk);
      check_count("enable pending", 0, pending);
    end
    fetch_and_check("enable miss", 32'h0000_100C, 8'h21, 1, -1);
    check_ar("enable AR", '{addr: 32'h0000_1000, len: icache_pkg::AXI_LEN_LINE}, last_ar);
    for (int w = 0; w < icache_pkg::LINE_WORDS; w++)
      fetch_and_check("enable hit", 32'h0000_1000 + 4 * w, 8'(8'h30 + w), 0, 2);
    finish_test("enable");
  endtask

  // A, B and C all map to set 4
  task automatic test_replacement();
    int ar_start;
    ar_start = ar_count;
    fetch_and_check("repl A miss", 32'h0000_1040, 8'h41, 1, -1);
    fetch_and_check("repl B miss", 32'h0000_1244, 8'h42, 1, -1);
    fetch_and_check("repl A hit", 32'h0000_1048, 8'h43, 0, 2);
    fetch_and_check("repl B hit", 32'h0000_124C, 8'h44, 0, 2);
    fetch_and_check("repl C miss", 32'h0000_1440, 8'h45, 1, -1);  // Victim is way 0, line A
    check_ar("repl C AR", '{addr: 32'h0000_1440, len: icache_pkg::AXI_LEN_LINE}, last_ar);
    fetch_and_check("repl B kept", 32'h0000_1240, 8'h46, 0, 2);
    fetch_and_check("repl A evicted", 32'h0000_1044, 8'h47, 1, -1);
    check_count("repl AR total", 4, ar_count - ar_start);
    finish_test("replacement");
  endtask

  task automatic test_backpressure();
    int ar_start;
    stall_pct = 8'd70;
    request_mode(1'b1);
    ar_start = ar_count;
    for (int k = 0; k < 4; k++)
      fetch_and_check("stall miss", 32'h0000_3004 + 16 * k, 8'(8'h50 + k), 1, -1);
    for (int k = 0; k < 4; k++)
      fetch_and_check("stall hit", 32'h0000_3008 + 16 * k, 8'(8'h58 + k), 0, 2);
    fetch_and_check("stall conflict miss", 32'h0000_3200, 8'h5C, 1, -1);
    fetch_and_check("stall way0 hit", 32'h0000_300C, 8'h5D, 0, 2);
    check_count("stall AR total", 5, ar_count - ar_start);
    stall_pct = 8'd25;
    finish_test("backpressure");
  endtask

  task automatic test_disable_reenable();
    request_mode(1'b0);
    fetch_and_check("disabled bypass", 32'h0000_3004, 8'h61, 1, -1);
    check_ar("disabled AR", '{addr: 32'h0000_3004, len: icache_pkg::AXI_LEN_WORD}, last_ar);
    request_mode(1'b1);
    fetch_and_check("reenable miss", 32'h0000_3004, 8'h62, 1, -1);
    check_ar("reenable AR", '{addr: 32'h0000_3000, len: icache_pkg::AXI_LEN_LINE}, last_ar);
    fetch_and_check("reenable hit", 32'h0000_3008, 8'h63, 0, 2);
    finish_test("disable_reenable");
  endtask

  initial
  begin
    fetch_req   = 1'b0;
    fetch_in    = '0;
    req_en      = 1'b0;
    req_dis     = 1'b0;
    stall_pct   = 8'd25;
    cycles      = 0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    rst_n       = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    test_bypass();
    test_enable();
    test_replacement();
    test_backpressure();
    test_disable_reenable();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hdl/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_ctrl.sv
hdl/refill_deserializer.sv
hdl/axi_ar_buffer.sv
hdl/icache_top.sv
sim/axi_rd_slave.sv
sim/icache_tb.sv
